//--- Bender.yml
package:
  name: voq_in_module

sources:
  - verilog/voq_cfg_pkg.sv
  - verilog/voq_frame_pkg.sv
  - verilog/lane_if.sv
  - verilog/reg_fifo.sv
  - verilog/ingress_parser.sv
  - verilog/port_lane.sv
  - verilog/egress_sequencer.sv
  - verilog/voq_in_module.sv
  - target: test
    files:
      - sim/tb_voq_in_module.sv

//--- project.f
verilog/voq_cfg_pkg.sv
verilog/voq_frame_pkg.sv
verilog/lane_if.sv
verilog/reg_fifo.sv
verilog/ingress_parser.sv
verilog/port_lane.sv
verilog/egress_sequencer.sv
verilog/voq_in_module.sv
sim/tb_voq_in_module.sv

//--- sim/tb_voq_in_module.sv
`timescale 1ns/1ps

module tb_voq_in_module;

    localparam int WAIT_LIMIT  = 2000;
    localparam int DRAIN_LIMIT = 4000;
    localparam int HOLD_CYCLES = 20;    // Full cycles seen before the held downstream lets go

    typedef struct packed {
        logic [voq_cfg_pkg::SEL_WIDTH-1:0]                                  dest;
        logic [voq_frame_pkg::RSVD_WIDTH-1:0]                               rsvd;
        logic [voq_frame_pkg::LEN_WIDTH-1:0]                                len;
        logic [voq_frame_pkg::PRIO_WIDTH-1:0]                               prio;
        logic [voq_frame_pkg::CRC_WIDTH-1:0]                                crc;
        logic [voq_cfg_pkg::MAX_PAYLOAD-1:0][voq_cfg_pkg::DATA_WIDTH-1:0]   pay;
    } pkt_t;

    logic                               clk;
    logic                               reset;
    logic [voq_cfg_pkg::PORT_WIDTH-1:0] data_in;
    logic                               wr_en_in;
    logic                               voq_full;
    logic [voq_cfg_pkg::PORT_WIDTH-1:0] data_out;
    logic                               wr_en_out;
    logic                               full;

    logic [31:0]                        lfsr;
    int                                 full_mode;    // 0 low, 1 random, 2 held until full rises
    int                                 full_seen;
    int                                 errors;
    int                                 checks;
    int                                 out_count;
    int                                 expected_total;
    voq_frame_pkg::word_t               exp_q [$];
    pkt_t                               sent_pkts [$];

    voq_in_module i_voq_in_module (
        .clk       (clk),
        .reset     (reset),
        .data_in   (data_in),
        .wr_en_in  (wr_en_in),
        .voq_full  (voq_full),
        .data_out  (data_out),
        .wr_en_out (wr_en_out),
        .full      (full)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[62:0], lfsr[0]};
        end
        return r;
    endfunction

    // Word idx of the output a packet should produce, the header being word 0
    function automatic voq_frame_pkg::word_t expected_word(input pkt_t p, input int idx);
        voq_frame_pkg::word_t w;
        w.sel = p.dest;
        if (idx == 0) begin
            w.data.hdr.rsvd   = p.rsvd;
            w.data.hdr.length = p.len;
            w.data.hdr.prio   = p.prio;
            w.data.hdr.crc    = p.crc;
        end else begin
            w.data.raw = p.pay[idx-1];
        end
        return w;
    endfunction

    task automatic compare_word(input string name, input voq_frame_pkg::word_t actual,
                                input voq_frame_pkg::word_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic compare_count(input string name, input int actual, input int expected);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, actual, expected);
        end
    endtask

    // One clock step; inputs change 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
        wr_en_in = 1'b0;
        case (full_mode)
            1: voq_full = (rand_bits(3) < 3);
            2: begin
                if (full) begin
                    full_seen++;
                end
                voq_full = (full_seen < HOLD_CYCLES);
            end
            default: voq_full = 1'b0;
        endcase
    endtask

    task automatic send_word(input voq_frame_pkg::word_t w, output bit ok);
        int waited;
        waited = 0;
        next_cycle();
        while (full && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        ok = !full;
        if (ok) begin
            data_in  = w;
            wr_en_in = 1'b1;
        end else begin
            errors++;
            $display("Timed out at %0t waiting for full to drop before an input word", $time);
        end
    endtask

    task automatic send_packet(input int dest, input int len, input bit gaps);
        pkt_t p;
        bit   ok;
        p.dest = voq_cfg_pkg::SEL_WIDTH'(dest);
        p.len  = voq_frame_pkg::LEN_WIDTH'(len);
        p.prio = rand_bits(voq_frame_pkg::PRIO_WIDTH);
        p.crc  = rand_bits(voq_frame_pkg::CRC_WIDTH);
        p.rsvd = rand_bits(voq_frame_pkg::RSVD_WIDTH);
        for (int k = 0; k < voq_cfg_pkg::MAX_PAYLOAD; k++) begin
            p.pay[k] = rand_bits(voq_cfg_pkg::DATA_WIDTH);
        end
        send_word({p.dest, p.rsvd, p.len, p.prio, p.crc}, ok);
        if (!ok) begin
            return;
        end
        sent_pkts.push_back(p);
        for (int k = 0; k <= len; k++) begin
            exp_q.push_back(expected_word(p, k));
        end
        expected_total += len + 1;
        for (int k = 0; k < len; k++) begin
            if (gaps) begin
                repeat (int'(rand_bits(2))) next_cycle();
            end
            send_word({p.dest, p.pay[k]}, ok);
            if (!ok) begin
                return;
            end
        end
    endtask

    task automatic send_random_packets(input int num, input bit gaps);
        for (int i = 0; i < num; i++) begin
            send_packet(int'(rand_bits(voq_cfg_pkg::SEL_WIDTH)), 1 + int'(rand_bits(3)), gaps);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("Timed out at %0t with %0d expected words never output", $time, exp_q.size());
            exp_q.delete();
        end
        repeat (4) next_cycle();    // Room for a stray extra word to show up
    endtask

    task automatic finish_test(input int num, input string name, input int err0,
                               input int out0, input int exp0);
        compare_count("output word count", out_count - out0, expected_total - exp0);
        $display("test %0d %s: %s", num, name, (errors == err0) ? "passed" : "failed");
    endtask

    always @(negedge clk) begin
        if (!reset && wr_en_out) begin
            out_count++;
            if (voq_full) begin
                errors++;
                $display("Output word written at %0t while downstream reported full", $time);
            end
            if (exp_q.size() == 0) begin
                errors++;
                $display("Word %h came out at %0t while nothing was expected", data_out, $time);
            end else begin
                compare_word("data_out", voq_frame_pkg::word_t'(data_out), exp_q.pop_front());
            end
        end
    end

    initial begin
        int err0;
        int out0;
        int exp0;
        int full_hi;
        int we_hi;
        lfsr           = 32'h5352d5f7;
        full_mode      = 0;
        full_seen      = 0;
        errors         = 0;
        checks         = 0;
        out_count      = 0;
        expected_total = 0;
        full_hi        = 0;
        we_hi          = 0;
        reset          = 1'b1;
        data_in        = '0;
        wr_en_in       = 1'b0;
        voq_full       = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        err0 = errors;
        out0 = out_count;
        exp0 = expected_total;
        for (int i = 0; i < 20; i++) begin
            next_cycle();
            @(negedge clk);
            full_hi += full;
            we_hi   += wr_en_out;
        end
        compare_count("full high cycles", full_hi, 0);
        compare_count("wr_en_out high cycles", we_hi, 0);
        finish_test(1, "idle after reset", err0, out0, exp0);

        err0 = errors;
        out0 = out_count;
        exp0 = expected_total;
        for (int p = 0; p < voq_cfg_pkg::PORT_NUM; p++) begin
            for (int k = 0; k < 2; k++) begin
                send_packet(p, ((p * 5 + k * 3) % voq_cfg_pkg::MAX_PAYLOAD) + 1, 1'b1);
                wait_drain();
            end
        end
        finish_test(2, "single packets per port", err0, out0, exp0);

        err0 = errors;
        out0 = out_count;
        exp0 = expected_total;
        send_random_packets(24, 1'b0);
        wait_drain();
        finish_test(3, "back to back mixed packets", err0, out0, exp0);

        err0 = errors;
        out0 = out_count;
        exp0 = expected_total;
        full_mode = 1;
        send_random_packets(24, 1'b1);
        wait_drain();
        full_mode = 0;
        finish_test(4, "random downstream full", err0, out0, exp0);

        err0 = errors;
        out0 = out_count;
        exp0 = expected_total;
        full_seen = 0;
        full_mode = 2;
        send_random_packets(16, 1'b0);    // Sixteen headers alone are enough to raise full
        wait_drain();
        full_mode = 0;
        if (full_seen == 0) begin
            errors++;
            $display("full never rose while downstream stayed full");
        end
        finish_test(5, "held downstream full", err0, out0, exp0);

        $display("checks: %0d, errors: %0d, words out: %0d, packets sent: %0d",
                 checks, errors, out_count, sent_pkts.size());
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- verilog/egress_sequencer.sv
`timescale 1ns/1ps

module egress_sequencer (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic [voq_frame_pkg::HDR_Q_WIDTH-1:0]       hdr_rd_data,
    input  logic                                        hdr_empty,
    output logic                                        hdr_rd_en,
    lane_if.seq_mp                                      lanes [voq_cfg_pkg::PORT_NUM],
    input  logic                                        voq_full,
    output voq_frame_pkg::word_t                        data_out,
    output logic                                        wr_en_out
);

    enum logic [1:0] {IDLE, SEND_HDR, SEND_PAY} state, state_next;

    voq_frame_pkg::word_t                   hdr_word;
    logic [voq_frame_pkg::LEN_WIDTH-1:0]    hdr_len;
    logic [voq_cfg_pkg::SEL_WIDTH-1:0]      cur_sel;
    logic [voq_frame_pkg::LEN_WIDTH-1:0]    remain;
    logic [voq_cfg_pkg::PORT_NUM-1:0]       lane_empty;
    voq_frame_pkg::word_t                   lane_data [voq_cfg_pkg::PORT_NUM];
    logic                                   hdr_pop;
    logic                                   pay_pop;
    logic                                   pay_last;
    logic                                   out_vld;

    assign hdr_word = hdr_rd_data[voq_cfg_pkg::PORT_WIDTH-1:0];
    assign hdr_len  = hdr_rd_data[voq_frame_pkg::HDR_Q_WIDTH-1 -: voq_frame_pkg::LEN_WIDTH];

    for (genvar i = 0; i < voq_cfg_pkg::PORT_NUM; i++) begin : g_lane
        assign lane_empty[i]  = lanes[i].empty;
        assign lane_data[i]   = lanes[i].rd_data;
        assign lanes[i].rd_en = pay_pop && (int'(cur_sel) == i);
    end

    // No queue is read while downstream is full
    assign hdr_pop   = (state != SEND_PAY) && !hdr_empty && !voq_full;
    assign pay_pop   = (state == SEND_PAY) && !lane_empty[cur_sel] && !voq_full;
    assign pay_last  = pay_pop && (remain == 1);
    assign hdr_rd_en = hdr_pop;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (hdr_pop) begin
                    state_next = (hdr_len == '0) ? IDLE : SEND_PAY;
                end else if (!hdr_empty) begin
                    state_next = SEND_HDR;    // Header waiting behind downstream full
                end
            end
            SEND_HDR: begin
                if (hdr_pop) begin
                    state_next = (hdr_len == '0) ? IDLE : SEND_PAY;
                end
            end
            SEND_PAY: begin
                if (pay_last) begin
                    state_next = hdr_empty ? IDLE : SEND_HDR;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE;
            cur_sel <= '0;
            remain  <= '0;
            out_vld <= 1'b0;
        end else begin
            state <= state_next;
            if (hdr_pop) begin
                cur_sel <= hdr_word.sel;
                remain  <= hdr_len;
            end else if (pay_pop) begin
                remain <= remain - 1'b1;
            end
            if (!voq_full) begin
                out_vld <= hdr_pop || pay_pop;    // A held word leaves once downstream frees
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_pop) begin
            data_out <= hdr_word;
        end else if (pay_pop) begin
            data_out <= lane_data[cur_sel];
        end
    end

    assign wr_en_out = out_vld && !voq_full;

endmodule

//--- verilog/ingress_parser.sv
`timescale 1ns/1ps

module ingress_parser (
    input  logic                                        clk,
    input  logic                                        reset,
    input  voq_frame_pkg::word_t                        data_in,
    input  logic                                        wr_en_in,
    output logic                                        hdr_wr_en,
    output logic [voq_frame_pkg::HDR_Q_WIDTH-1:0]       hdr_wr_data,
    input  logic [voq_cfg_pkg::HDR_CNT_WIDTH-1:0]       hdr_count,
    lane_if.parser_mp                                   lanes [voq_cfg_pkg::PORT_NUM],
    output logic                                        full
);

    logic [voq_frame_pkg::LEN_WIDTH-1:0]    remain;
    logic                                   is_header;
    logic [voq_cfg_pkg::PORT_NUM-1:0]       lane_room;
    logic                                   hdr_near_full;

    // Nothing left of the previous packet, so this word opens a new one
    assign is_header   = (remain == '0);

    assign hdr_wr_en   = wr_en_in && is_header;
    assign hdr_wr_data = {data_in.data.hdr.length, data_in};

    always_ff @(posedge clk) begin
        if (reset) begin
            remain <= '0;
        end else if (wr_en_in) begin
            if (is_header) begin
                remain <= data_in.data.hdr.length;
            end else begin
                remain <= remain - 1'b1;
            end
        end
    end

    for (genvar i = 0; i < voq_cfg_pkg::PORT_NUM; i++) begin : g_lane
        assign lanes[i].wr_en   = wr_en_in && !is_header && (int'(data_in.sel) == i);
        assign lanes[i].wr_data = data_in;
        assign lane_room[i]     = lanes[i].room;
    end

    // One entry of margin covers the cycle upstream needs to see full
    assign hdr_near_full = (int'(hdr_count) >= voq_cfg_pkg::HDR_DEPTH - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else begin
            full <= hdr_near_full || !(&lane_room);
        end
    end

endmodule

//--- verilog/lane_if.sv
`timescale 1ns/1ps

interface lane_if;

    logic                   wr_en;
    voq_frame_pkg::word_t   wr_data;
    logic                   room;       // At least one full packet still fits
    logic                   rd_en;
    voq_frame_pkg::word_t   rd_data;    // Head entry, valid while empty is low
    logic                   empty;

    modport parser_mp (
        output wr_en,
        output wr_data,
        input  room
    );

    modport lane_mp (
        input  wr_en,
        input  wr_data,
        output room,
        input  rd_en,
        output rd_data,
        output empty
    );

    modport seq_mp (
        output rd_en,
        input  rd_data,
        input  empty
    );

endinterface

//--- verilog/port_lane.sv
`timescale 1ns/1ps

module port_lane (
    input  logic        clk,
    input  logic        reset,
    lane_if.lane_mp     lane
);

    logic [voq_cfg_pkg::LANE_CNT_WIDTH-1:0]  count;
    logic [voq_cfg_pkg::PORT_WIDTH-1:0]      fifo_rd_data;
    int                                      free_slots;

    reg_fifo #(
        .WIDTH  (voq_cfg_pkg::PORT_WIDTH),
        .DEPTH  (voq_cfg_pkg::LANE_DEPTH)
    ) i_lane_fifo (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (lane.wr_en),
        .wr_data (lane.wr_data),
        .rd_en   (lane.rd_en),
        .rd_data (fifo_rd_data),
        .full    (),
        .empty   (lane.empty),
        .count   (count)
    );

    assign lane.rd_data = fifo_rd_data;

    // Room means a packet of the longest legal length still fits
    assign free_slots = voq_cfg_pkg::LANE_DEPTH - int'(count);
    assign lane.room  = (free_slots >= voq_cfg_pkg::MAX_PAYLOAD);

endmodule

//--- verilog/reg_fifo.sv
`timescale 1ns/1ps

module reg_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          wr_en,
    input  logic [WIDTH-1:0]              wr_data,
    input  logic                          rd_en,
    output logic [WIDTH-1:0]              rd_data,
    output logic                          full,
    output logic                          empty,
    output logic [$clog2(DEPTH+1)-1:0]    count
);

    logic [WIDTH-1:0]           mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic                       do_wr;
    logic                       do_rd;

    function automatic logic [$clog2(DEPTH)-1:0] ptr_next(input logic [$clog2(DEPTH)-1:0] ptr);
        if (int'(ptr) == DEPTH - 1) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign do_wr   = wr_en && !full;     // Writes into a full queue are dropped
    assign do_rd   = rd_en && !empty;
    assign full    = (int'(count) == DEPTH);
    assign empty   = (count == '0);
    assign rd_data = mem[rd_ptr];        // Show-ahead head entry

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- verilog/voq_cfg_pkg.sv
package voq_cfg_pkg;

    localparam int PORT_NUM       = 4;
    localparam int SEL_WIDTH      = $clog2(PORT_NUM);
    localparam int DATA_WIDTH     = 64;
    localparam int PORT_WIDTH     = SEL_WIDTH + DATA_WIDTH;    // Select on top of the data field

    localparam int MAX_PAYLOAD    = 8;                         // Longest legal packet body in words

    localparam int LANE_DEPTH     = 16;
    localparam int HDR_DEPTH      = 16;
    localparam int LANE_CNT_WIDTH = $clog2(LANE_DEPTH + 1);
    localparam int HDR_CNT_WIDTH  = $clog2(HDR_DEPTH + 1);

endpackage

//--- verilog/voq_frame_pkg.sv
package voq_frame_pkg;

    localparam int LEN_WIDTH   = 8;
    localparam int PRIO_WIDTH  = 2;
    localparam int CRC_WIDTH   = 32;
    localparam int RSVD_WIDTH  = voq_cfg_pkg::DATA_WIDTH - LEN_WIDTH - PRIO_WIDTH - CRC_WIDTH;

    // Header queue entry keeps the length beside the header word
    localparam int HDR_Q_WIDTH = voq_cfg_pkg::PORT_WIDTH + LEN_WIDTH;

    typedef struct packed {
        logic [RSVD_WIDTH-1:0] rsvd;
        logic [LEN_WIDTH-1:0]  length;    // Payload words that follow the header
        logic [PRIO_WIDTH-1:0] prio;
        logic [CRC_WIDTH-1:0]  crc;
    } header_t;

    typedef union packed {
        header_t                             hdr;
        logic [voq_cfg_pkg::DATA_WIDTH-1:0]  raw;
    } data_u;

    typedef struct packed {
        logic [voq_cfg_pkg::SEL_WIDTH-1:0]   sel;
        data_u                               data;
    } word_t;

endpackage

//--- verilog/voq_in_module.sv
`timescale 1ns/1ps

module voq_in_module (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic [voq_cfg_pkg::PORT_WIDTH-1:0]      data_in,
    input  logic                                    wr_en_in,
    input  logic                                    voq_full,
    output logic [voq_cfg_pkg::PORT_WIDTH-1:0]      data_out,
    output logic                                    wr_en_out,
    output logic                                    full
);

    voq_frame_pkg::word_t                           in_word;
    voq_frame_pkg::word_t                           out_word;

    logic                                           hdr_wr_en;
    logic [voq_frame_pkg::HDR_Q_WIDTH-1:0]          hdr_wr_data;
    logic                                           hdr_rd_en;
    logic [voq_frame_pkg::HDR_Q_WIDTH-1:0]          hdr_rd_data;
    logic                                           hdr_empty;
    logic [voq_cfg_pkg::HDR_CNT_WIDTH-1:0]          hdr_count;

    lane_if lanes [voq_cfg_pkg::PORT_NUM] ();

    assign in_word.sel      = data_in[voq_cfg_pkg::PORT_WIDTH-1 -: voq_cfg_pkg::SEL_WIDTH];
    assign in_word.data.raw = data_in[voq_cfg_pkg::DATA_WIDTH-1:0];
    assign data_out         = {out_word.sel, out_word.data.raw};

    reg_fifo #(
        .WIDTH  (voq_frame_pkg::HDR_Q_WIDTH),
        .DEPTH  (voq_cfg_pkg::HDR_DEPTH)
    ) i_hdr_fifo (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (hdr_wr_en),
        .wr_data (hdr_wr_data),
        .rd_en   (hdr_rd_en),
        .rd_data (hdr_rd_data),
        .full    (),
        .empty   (hdr_empty),
        .count   (hdr_count)
    );

    ingress_parser i_ingress_parser (
        .clk         (clk),
        .reset       (reset),
        .data_in     (in_word),
        .wr_en_in    (wr_en_in),
        .hdr_wr_en   (hdr_wr_en),
        .hdr_wr_data (hdr_wr_data),
        .hdr_count   (hdr_count),
        .lanes       (lanes),
        .full        (full)
    );

    for (genvar i = 0; i < voq_cfg_pkg::PORT_NUM; i++) begin : g_port
        port_lane i_port_lane (
            .clk   (clk),
            .reset (reset),
            .lane  (lanes[i])
        );
    end

    egress_sequencer i_egress_sequencer (
        .clk         (clk),
        .reset       (reset),
        .hdr_rd_data (hdr_rd_data),
        .hdr_empty   (hdr_empty),
        .hdr_rd_en   (hdr_rd_en),
        .lanes       (lanes),
        .voq_full    (voq_full),
        .data_out    (out_word),
        .wr_en_out   (wr_en_out)
    );

endmodule
